// File: hw/rtf64_r1_pkg.sv
// ==========================================================
// Shared constants for the one-source-register integer unit
// Function, size and merge codes are chosen for this unit and
// do not follow any external opcode map
// ==========================================================
package rtf64_r1_pkg;

  // Data word width
  localparam int WID = 64;

  // Instruction field positions
  localparam int FN_LSB  = 18;
  localparam int FN_W    = 5;
  localparam int SZ_LSB  = 23;
  localparam int SZ_W    = 3;
  localparam int MOP_LSB = 10;
  localparam int MOP_W   = 3;

  // Raw function codes as they appear in the instruction word
  localparam logic [FN_W-1:0] FN_COM    = 5'd0;
  localparam logic [FN_W-1:0] FN_NOT    = 5'd1;
  localparam logic [FN_W-1:0] FN_NEG    = 5'd2;
  localparam logic [FN_W-1:0] FN_TST    = 5'd3;
  localparam logic [FN_W-1:0] FN_PTRINC = 5'd4;

  // Decoded function carried down the pipeline
  typedef enum logic [2:0] {
    R1_COM    = 3'd0,
    R1_NOT    = 3'd1,
    R1_NEG    = 3'd2,
    R1_TST    = 3'd3,
    R1_PTRINC = 3'd4
  } r1_fn_e;

  // Size codes; lane sizes operate on each lane separately
  localparam logic [SZ_W-1:0] SZ_OCTA     = 3'd0;
  localparam logic [SZ_W-1:0] SZ_TETRA    = 3'd1;
  localparam logic [SZ_W-1:0] SZ_WYDE     = 3'd2;
  localparam logic [SZ_W-1:0] SZ_BYTE     = 3'd3;
  localparam logic [SZ_W-1:0] SZ_OCTA_ALT = 3'd4;
  localparam logic [SZ_W-1:0] SZ_LANE32   = 3'd5;
  localparam logic [SZ_W-1:0] SZ_LANE16   = 3'd6;
  localparam logic [SZ_W-1:0] SZ_LANE8    = 3'd7;

  // Condition merge modes
  localparam logic [MOP_W-1:0] MOP_CPY   = 3'd0;
  localparam logic [MOP_W-1:0] MOP_AND   = 3'd1;
  localparam logic [MOP_W-1:0] MOP_OR    = 3'd2;
  localparam logic [MOP_W-1:0] MOP_ANDCM = 3'd3;
  localparam logic [MOP_W-1:0] MOP_ORCM  = 3'd4;

  // Condition byte bit positions; bits 2, 3 and 6 read as zero
  localparam int CR_NZ  = 0;
  localparam int CR_Z   = 1;
  localparam int CR_PAR = 4;
  localparam int CR_ODD = 5;
  localparam int CR_NEG = 7;

endpackage

// File: hw/r1_decode.sv
// ==========================================================
// Issue stage of the integer unit
// Holds one instruction; in_ready drops only while the stage
// is full and the result stage cannot take its contents
// ==========================================================
`timescale 1ns/1ps

module r1_decode (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic [31:0]                   ir,
  input  logic [rtf64_r1_pkg::WID-1:0]  ia,
  input  logic [rtf64_r1_pkg::WID-1:0]  id,
  input  logic [7:0]                    cdb,
  input  logic                          stage_ready,
  output logic                          dec_valid,
  output rtf64_r1_pkg::r1_fn_e          dec_fn,
  output logic [2:0]                    dec_size,
  output logic [2:0]                    dec_mop,
  output logic                          dec_illegal,
  output logic [rtf64_r1_pkg::WID-1:0]  dec_ia,
  output logic [rtf64_r1_pkg::WID-1:0]  dec_id,
  output logic [7:0]                    dec_cdb
);
  import rtf64_r1_pkg::*;

  logic [FN_W-1:0]  fn_code;
  logic [SZ_W-1:0]  sz_code;
  logic [MOP_W-1:0] mop_code;
  r1_fn_e           fn_dec;
  logic             illegal;
  logic             accept;

  assign fn_code  = ir[FN_LSB +: FN_W];
  assign sz_code  = ir[SZ_LSB +: SZ_W];
  assign mop_code = ir[MOP_LSB +: MOP_W];

  // ==========================================================
  // Field decode and legality check
  // ==========================================================
  always_comb
  begin
    fn_dec  = R1_COM;
    illegal = 1'b0;
    case (fn_code)
      FN_COM:
        illegal = sz_code > SZ_OCTA_ALT;
      FN_NOT:
        fn_dec = R1_NOT;
      FN_NEG:
        fn_dec = R1_NEG;
      FN_TST:
      begin
        fn_dec  = R1_TST;
        illegal = (sz_code > SZ_BYTE) || (mop_code > MOP_ORCM);
      end
      FN_PTRINC:
      begin
        fn_dec  = R1_PTRINC;
        illegal = sz_code == SZ_OCTA;
      end
      default:
        illegal = 1'b1;
    endcase
  end

  // ==========================================================
  // Stage register
  // ==========================================================
  assign in_ready = !dec_valid || stage_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      dec_valid <= 1'b0;
    else if (accept)
      dec_valid <= 1'b1;
    else if (stage_ready)
      dec_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      dec_fn      <= fn_dec;
      dec_size    <= sz_code;
      dec_mop     <= mop_code;
      dec_illegal <= illegal;
      dec_ia      <= ia;
      dec_id      <= id;
      dec_cdb     <= cdb;
    end
  end

endmodule

// File: hw/r1_execute.sv
// ==========================================================
// Combinational compute for the integer unit
// Scalar COM and NEG keep the bits above the narrow part from
// the old destination; outputs are zero when not written
// ==========================================================
`timescale 1ns/1ps

module r1_execute (
  input  rtf64_r1_pkg::r1_fn_e          dec_fn,
  input  logic [2:0]                    dec_size,
  input  logic [2:0]                    dec_mop,
  input  logic                          dec_illegal,
  input  logic [rtf64_r1_pkg::WID-1:0]  dec_ia,
  input  logic [rtf64_r1_pkg::WID-1:0]  dec_id,
  input  logic [7:0]                    dec_cdb,
  output logic [rtf64_r1_pkg::WID-1:0]  exe_res,
  output logic [7:0]                    exe_crres,
  output logic                          exe_res_we,
  output logic                          exe_cr_we
);
  import rtf64_r1_pkg::*;

  logic [WID-1:0] mask;
  logic [WID-1:0] narrow;
  logic           top_bit;
  logic [WID-1:0] lane_neg;
  logic [WID-1:0] lane_not;
  logic [WID-1:0] word_res;
  logic [7:0]     raw_cr;
  logic [7:0]     merged_cr;
  logic [7:0]     cr_keep;
  logic           is_lane;

  assign is_lane = dec_size >= SZ_LANE32;

  // Narrow part of the operand and its sign bit
  always_comb
  begin
    case (dec_size)
      SZ_TETRA:
      begin
        mask    = {{(WID-32){1'b0}}, {32{1'b1}}};
        top_bit = dec_ia[31];
      end
      SZ_WYDE:
      begin
        mask    = {{(WID-16){1'b0}}, {16{1'b1}}};
        top_bit = dec_ia[15];
      end
      SZ_BYTE:
      begin
        mask    = {{(WID-8){1'b0}}, {8{1'b1}}};
        top_bit = dec_ia[7];
      end
      default:
      begin
        mask    = '1;
        top_bit = dec_ia[WID-1];
      end
    endcase
  end

  assign narrow = dec_ia & mask;

  // ==========================================================
  // Lane-parallel NEG and NOT
  // ==========================================================
  always_comb
  begin
    lane_neg = '0;
    lane_not = '0;
    case (dec_size)
      SZ_LANE32:
        for (int i = 0; i < WID / 32; i++)
        begin
          lane_neg[i*32 +: 32] = -dec_ia[i*32 +: 32];
          lane_not[i*32 + 31]  = dec_ia[i*32 +: 32] == '0;
        end
      SZ_LANE16:
        for (int i = 0; i < WID / 16; i++)
        begin
          lane_neg[i*16 +: 16] = -dec_ia[i*16 +: 16];
          lane_not[i*16 + 15]  = dec_ia[i*16 +: 16] == '0;
        end
      SZ_LANE8:
        for (int i = 0; i < WID / 8; i++)
        begin
          lane_neg[i*8 +: 8] = -dec_ia[i*8 +: 8];
          lane_not[i*8 + 7]  = dec_ia[i*8 +: 8] == '0;
        end
      default:
        ;
    endcase
  end

  // ==========================================================
  // Word result
  // ==========================================================
  always_comb
  begin
    case (dec_fn)
      R1_COM:
        word_res = (~dec_ia & mask) | (dec_id & ~mask);
      R1_NOT:
        word_res = is_lane ? lane_not : {{(WID-1){1'b0}}, narrow == '0};
      R1_NEG:
        // Low bits of a negate depend only on the low bits of ia
        word_res = is_lane ? lane_neg : ((-dec_ia & mask) | (dec_id & ~mask));
      R1_PTRINC:
        if (dec_ia[2:0] >= dec_size)
          word_res = {dec_ia[WID-1:3] + 1'b1, 3'b000};
        else
          word_res = dec_ia + 1'b1;
      default:
        word_res = '0;
    endcase
  end

  // ==========================================================
  // Condition byte for TST, merged with the incoming byte
  // ==========================================================
  always_comb
  begin
    raw_cr         = '0;
    raw_cr[CR_NZ]  = |narrow;
    raw_cr[CR_Z]   = ~|narrow;
    raw_cr[CR_PAR] = ^narrow;
    raw_cr[CR_ODD] = dec_ia[0];
    raw_cr[CR_NEG] = top_bit;

    cr_keep         = '0;
    cr_keep[CR_NZ]  = 1'b1;
    cr_keep[CR_Z]   = 1'b1;
    cr_keep[CR_PAR] = 1'b1;
    cr_keep[CR_ODD] = 1'b1;
    cr_keep[CR_NEG] = 1'b1;

    case (dec_mop)
      MOP_AND:   merged_cr = dec_cdb & raw_cr;
      MOP_OR:    merged_cr = dec_cdb | raw_cr;
      MOP_ANDCM: merged_cr = dec_cdb & ~raw_cr;
      MOP_ORCM:  merged_cr = dec_cdb | ~raw_cr;
      default:   merged_cr = raw_cr;
    endcase
  end

  assign exe_res_we = !dec_illegal && (dec_fn != R1_TST);
  assign exe_cr_we  = !dec_illegal && (dec_fn == R1_TST);

  assign exe_res   = exe_res_we ? word_res : '0;
  assign exe_crres = exe_cr_we ? (merged_cr & cr_keep) : '0;

endmodule

// File: hw/r1_result.sv
// ==========================================================
// Output stage of the integer unit
// Holds one result until the consumer takes it; a new result
// can enter in the same cycle the old one leaves
// ==========================================================
`timescale 1ns/1ps

module r1_result (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          dec_valid,
  input  logic [rtf64_r1_pkg::WID-1:0]  exe_res,
  input  logic [7:0]                    exe_crres,
  input  logic                          exe_res_we,
  input  logic                          exe_cr_we,
  input  logic                          dec_illegal,
  output logic                          stage_ready,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [rtf64_r1_pkg::WID-1:0]  res,
  output logic [7:0]                    crres,
  output logic                          res_we,
  output logic                          cr_we,
  output logic                          illegal
);

  logic load;

  assign stage_ready = !out_valid || out_ready;
  assign load        = dec_valid && stage_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      out_valid <= 1'b0;
    else if (load)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  // Result payload follows the valid bit
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      res     <= exe_res;
      crres   <= exe_crres;
      res_we  <= exe_res_we;
      cr_we   <= exe_cr_we;
      illegal <= dec_illegal;
    end
  end

endmodule

// File: hw/rtf64_r1_unit.sv
// ==========================================================
// Top of the one-source-register integer unit
// Two stages, decode then result; one result per cycle while
// out_ready stays high, results leave in issue order
// ==========================================================
`timescale 1ns/1ps

module rtf64_r1_unit (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic [31:0]                   ir,
  input  logic [rtf64_r1_pkg::WID-1:0]  ia,
  input  logic [rtf64_r1_pkg::WID-1:0]  id,
  input  logic [7:0]                    cdb,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [rtf64_r1_pkg::WID-1:0]  res,
  output logic [7:0]                    crres,
  output logic                          res_we,
  output logic                          cr_we,
  output logic                          illegal
);
  import rtf64_r1_pkg::*;

  logic           stage_ready;
  logic           dec_valid;
  r1_fn_e         dec_fn;
  logic [2:0]     dec_size;
  logic [2:0]     dec_mop;
  logic           dec_illegal;
  logic [WID-1:0] dec_ia;
  logic [WID-1:0] dec_id;
  logic [7:0]     dec_cdb;
  logic [WID-1:0] exe_res;
  logic [7:0]     exe_crres;
  logic           exe_res_we;
  logic           exe_cr_we;

  r1_decode decode_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .ir          (ir),
    .ia          (ia),
    .id          (id),
    .cdb         (cdb),
    .stage_ready (stage_ready),
    .dec_valid   (dec_valid),
    .dec_fn      (dec_fn),
    .dec_size    (dec_size),
    .dec_mop     (dec_mop),
    .dec_illegal (dec_illegal),
    .dec_ia      (dec_ia),
    .dec_id      (dec_id),
    .dec_cdb     (dec_cdb)
  );

  // Compute sits between the two registers and adds no cycle
  r1_execute execute_i (
    .dec_fn      (dec_fn),
    .dec_size    (dec_size),
    .dec_mop     (dec_mop),
    .dec_illegal (dec_illegal),
    .dec_ia      (dec_ia),
    .dec_id      (dec_id),
    .dec_cdb     (dec_cdb),
    .exe_res     (exe_res),
    .exe_crres   (exe_crres),
    .exe_res_we  (exe_res_we),
    .exe_cr_we   (exe_cr_we)
  );

  r1_result result_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .dec_valid   (dec_valid),
    .exe_res     (exe_res),
    .exe_crres   (exe_crres),
    .exe_res_we  (exe_res_we),
    .exe_cr_we   (exe_cr_we),
    .dec_illegal (dec_illegal),
    .stage_ready (stage_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .res         (res),
    .crres       (crres),
    .res_we      (res_we),
    .cr_we       (cr_we),
    .illegal     (illegal)
  );

endmodule

// File: sim/r1_unit_vectors.svh
// ==========================================================
// Directed rows for the integer unit testbench
// Each row is the instruction word, ia, id and cdb, then the
// expected res, crres and {res_we, cr_we, illegal}
// Rows are checked in the order they are pushed here
// ==========================================================

localparam logic [WID-1:0] IA0 = 64'h0123_4567_89AB_CDEF;
localparam logic [WID-1:0] ID0 = 64'h5555_AAAA_5555_AAAA;

task automatic load_vectors();
  // Scalar COM and NEG keep id above the narrow part
  add_row(enc_ir(FN_COM, SZ_OCTA, MOP_CPY), IA0, ID0, 8'h00,
          64'hFEDC_BA98_7654_3210, 8'h00, 3'b100);
  add_row(enc_ir(FN_COM, SZ_TETRA, MOP_CPY), IA0, ID0, 8'h00,
          64'h5555_AAAA_7654_3210, 8'h00, 3'b100);
  add_row(enc_ir(FN_COM, SZ_WYDE, MOP_CPY), IA0, ID0, 8'h00,
          64'h5555_AAAA_5555_3210, 8'h00, 3'b100);
  add_row(enc_ir(FN_COM, SZ_BYTE, MOP_CPY), IA0, ID0, 8'h00,
          64'h5555_AAAA_5555_AA10, 8'h00, 3'b100);
  add_row(enc_ir(FN_COM, SZ_OCTA_ALT, MOP_CPY), IA0, ID0, 8'h00,
          64'hFEDC_BA98_7654_3210, 8'h00, 3'b100);
  add_row(enc_ir(FN_NEG, SZ_OCTA, MOP_CPY), IA0, ID0, 8'h00,
          64'hFEDC_BA98_7654_3211, 8'h00, 3'b100);
  add_row(enc_ir(FN_NEG, SZ_TETRA, MOP_CPY), IA0, ID0, 8'h00,
          64'h5555_AAAA_7654_3211, 8'h00, 3'b100);
  add_row(enc_ir(FN_NEG, SZ_WYDE, MOP_CPY), IA0, ID0, 8'h00,
          64'h5555_AAAA_5555_3211, 8'h00, 3'b100);
  add_row(enc_ir(FN_NEG, SZ_BYTE, MOP_CPY), IA0, ID0, 8'h00,
          64'h5555_AAAA_5555_AA11, 8'h00, 3'b100);
  add_row(enc_ir(FN_NEG, SZ_OCTA_ALT, MOP_CPY), IA0, ID0, 8'h00,
          64'hFEDC_BA98_7654_3211, 8'h00, 3'b100);

  // Lane NEG with zero lanes and most negative lanes
  add_row(enc_ir(FN_NEG, SZ_LANE32, MOP_CPY), 64'h8000_0000_0000_0001, ID0, 8'h00,
          64'h8000_0000_FFFF_FFFF, 8'h00, 3'b100);
  add_row(enc_ir(FN_NEG, SZ_LANE16, MOP_CPY), 64'h8000_0000_0001_7FFF, ID0, 8'h00,
          64'h8000_0000_FFFF_8001, 8'h00, 3'b100);
  add_row(enc_ir(FN_NEG, SZ_LANE8, MOP_CPY), 64'h8000_0102_FF7F_1000, ID0, 8'h00,
          64'h8000_FFFE_0181_F000, 8'h00, 3'b100);

  // Lane NOT sets the top bit of every zero lane
  add_row(enc_ir(FN_NOT, SZ_LANE32, MOP_CPY), 64'h0000_0000_0000_0100, ID0, 8'h00,
          64'h8000_0000_0000_0000, 8'h00, 3'b100);
  add_row(enc_ir(FN_NOT, SZ_LANE16, MOP_CPY), 64'h0000_8000_0000_0001, ID0, 8'h00,
          64'h8000_0000_8000_0000, 8'h00, 3'b100);
  add_row(enc_ir(FN_NOT, SZ_LANE8, MOP_CPY), 64'h0080_0000_FF00_0100, ID0, 8'h00,
          64'h8000_8080_0080_0080, 8'h00, 3'b100);
  add_row(enc_ir(FN_NOT, SZ_TETRA, MOP_CPY), 64'hFFFF_FFFF_0000_0000, ID0, 8'h00,
          64'h0000_0000_0000_0001, 8'h00, 3'b100);
  add_row(enc_ir(FN_NOT, SZ_OCTA, MOP_CPY), 64'hFFFF_FFFF_0000_0000, ID0, 8'h00,
          64'h0, 8'h00, 3'b100);

  // TST writes only the condition byte
  add_row(enc_ir(FN_TST, SZ_BYTE, MOP_CPY), 64'h0000_0000_0000_0083, ID0, 8'h00,
          64'h0, 8'hB1, 3'b010);
  add_row(enc_ir(FN_TST, SZ_OCTA, MOP_ANDCM), 64'h0000_0000_0000_0083, ID0, 8'hFF,
          64'h0, 8'h82, 3'b010);
  add_row(enc_ir(FN_TST, SZ_WYDE, MOP_ORCM), 64'hFFFF_FFFF_FFFF_0000, ID0, 8'h00,
          64'h0, 8'hB1, 3'b010);
  add_row(enc_ir(FN_TST, SZ_TETRA, MOP_OR), 64'h0000_0000_8000_0000, ID0, 8'h00,
          64'h0, 8'h91, 3'b010);

  // PTRINC rounds up to the next multiple of 8 or adds 1
  add_row(enc_ir(FN_PTRINC, SZ_BYTE, MOP_CPY), 64'h0000_0000_0000_1006, ID0, 8'h00,
          64'h0000_0000_0000_1008, 8'h00, 3'b100);
  add_row(enc_ir(FN_PTRINC, SZ_LANE32, MOP_CPY), 64'h0000_0000_0000_1001, ID0, 8'h00,
          64'h0000_0000_0000_1002, 8'h00, 3'b100);
  add_row(enc_ir(FN_PTRINC, SZ_LANE8, MOP_CPY), 64'h0000_0000_FFFF_FFFF, ID0, 8'h00,
          64'h0000_0001_0000_0000, 8'h00, 3'b100);

  // Illegal codes write nothing
  add_row(enc_ir(5'd5, SZ_OCTA, MOP_CPY), IA0, ID0, 8'hFF, 64'h0, 8'h00, 3'b001);
  add_row(enc_ir(FN_TST, SZ_BYTE, 3'd5), IA0, ID0, 8'hFF, 64'h0, 8'h00, 3'b001);
  add_row(enc_ir(FN_TST, SZ_LANE16, MOP_CPY), IA0, ID0, 8'hFF, 64'h0, 8'h00, 3'b001);
  add_row(enc_ir(FN_PTRINC, SZ_OCTA, MOP_CPY), IA0, ID0, 8'hFF, 64'h0, 8'h00, 3'b001);
endtask

// File: sim/r1_unit_tb.sv
// ==========================================================
// Testbench for the one-source-register integer unit
// Directed rows first with out_ready held high, then random
// rows with random back-pressure; stops at the first error
// ==========================================================
`timescale 1ns/1ps

module r1_unit_tb;
  import rtf64_r1_pkg::*;

  localparam int WAIT_LIMIT = 100;

  typedef struct packed {
    logic [31:0]    ir;
    logic [WID-1:0] ia;
    logic [WID-1:0] id;
    logic [7:0]     cdb;
    logic [WID-1:0] res;
    logic [7:0]     crres;
    logic [2:0]     flags;
  } row_t;

  logic           clk;
  logic           arst_n;
  logic           in_valid;
  logic           in_ready;
  logic [31:0]    ir;
  logic [WID-1:0] ia;
  logic [WID-1:0] id;
  logic [7:0]     cdb;
  logic           out_valid;
  logic           out_ready;
  logic [WID-1:0] res;
  logic [7:0]     crres;
  logic           res_we;
  logic           cr_we;
  logic           illegal;

  row_t   rows[$];
  row_t   expect_q[$];
  int     accept_q[$];
  int     cycle;
  integer seed;

  rtf64_r1_unit dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .ir        (ir),
    .ia        (ia),
    .id        (id),
    .cdb       (cdb),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .res       (res),
    .crres     (crres),
    .res_we    (res_we),
    .cr_we     (cr_we),
    .illegal   (illegal)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] enc_ir(input logic [4:0] fn, input logic [2:0] sz,
                                         input logic [2:0] mop);
    logic [31:0] w;
    w                    = '0;
    w[FN_LSB +: FN_W]    = fn;
    w[SZ_LSB +: SZ_W]    = sz;
    w[MOP_LSB +: MOP_W]  = mop;
    return w;
  endfunction

  task automatic add_row(input logic [31:0] ir_v, input logic [WID-1:0] ia_v,
                         input logic [WID-1:0] id_v, input logic [7:0] cdb_v,
                         input logic [WID-1:0] res_v, input logic [7:0] cr_v,
                         input logic [2:0] flags_v);
    rows.push_back('{ir_v, ia_v, id_v, cdb_v, res_v, cr_v, flags_v});
  endtask

  `include "r1_unit_vectors.svh"

  // ==========================================================
  // Reference model of the execution rules
  // ==========================================================
  function automatic row_t model_row(input logic [31:0] ir_v, input logic [WID-1:0] ia_v,
                                     input logic [WID-1:0] id_v, input logic [7:0] cdb_v);
    row_t           r;
    int             fn;
    int             sz;
    int             mop;
    int             bits;
    int             lw;
    int             i;
    logic [WID-1:0] lo;
    logic [WID-1:0] part;
    logic [WID-1:0] lane;
    logic [7:0]     raw;
    r     = '0;
    r.ir  = ir_v;
    r.ia  = ia_v;
    r.id  = id_v;
    r.cdb = cdb_v;
    fn    = ir_v[FN_LSB +: FN_W];
    sz    = ir_v[SZ_LSB +: SZ_W];
    mop   = ir_v[MOP_LSB +: MOP_W];
    bits  = (sz == 1) ? 32 : (sz == 2) ? 16 : (sz == 3) ? 8 : 64;
    lw    = (sz == 5) ? 32 : (sz == 6) ? 16 : 8;
    lo    = {WID{1'b1}} >> (64 - bits);
    part  = ia_v & lo;
    if (fn > 4 || (fn == 0 && sz > 4) || (fn == 3 && (sz > 3 || mop > 4)) ||
        (fn == 4 && sz == 0))
      r.flags = 3'b001;
    else if (fn == 3)
    begin
      raw    = 8'h00;
      raw[0] = part != 0;
      raw[1] = part == 0;
      raw[4] = ^part;
      raw[5] = ia_v[0];
      raw[7] = ia_v[bits-1];
      case (mop)
        1: raw = cdb_v & raw;
        2: raw = cdb_v | raw;
        3: raw = cdb_v & ~raw;
        4: raw = cdb_v | ~raw;
        default: ;
      endcase
      // Bits 2, 3 and 6 never survive the merge
      r.crres = raw & 8'hB3;
      r.flags = 3'b010;
    end
    else
    begin
      r.flags = 3'b100;
      if (fn == 4)
        r.res = (ia_v[2:0] >= sz) ? (ia_v & ~64'h7) + 64'd8 : ia_v + 64'd1;
      else if (sz >= 5)
        for (i = 0; i < WID / lw; i++)
        begin
          lane = (ia_v >> (i * lw)) & ({WID{1'b1}} >> (64 - lw));
          if (fn == 1)
            r.res[i*lw + lw - 1] = lane == 0;
          else
            r.res = r.res | (((~lane + 64'd1) & ({WID{1'b1}} >> (64 - lw))) << (i * lw));
        end
      else if (fn == 1)
        r.res = (part == 0) ? 64'd1 : 64'd0;
      else if (fn == 0)
        r.res = (~ia_v & lo) | (id_v & ~lo);
      else
        r.res = ((~ia_v + 64'd1) & lo) | (id_v & ~lo);
    end
    return r;
  endfunction

  // ==========================================================
  // Error reporting and compare tasks
  // ==========================================================
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_res(input logic [WID-1:0] got, input logic [WID-1:0] exp,
                           input logic [31:0] ir_v);
    if (got !== exp)
      report_fail($sformatf("Mismatch at %0t: ir %h res got %h expected %h",
                            $time, ir_v, got, exp));
  endtask

  task automatic check_cr(input logic [7:0] got, input logic [7:0] exp,
                          input logic [31:0] ir_v);
    if (got !== exp)
      report_fail($sformatf("Mismatch at %0t: ir %h crres got %h expected %h",
                            $time, ir_v, got, exp));
  endtask

  task automatic check_flags(input logic res_we_v, input logic cr_we_v,
                             input logic illegal_v, input logic [2:0] exp,
                             input logic [31:0] ir_v);
    if ({res_we_v, cr_we_v, illegal_v} !== exp)
      report_fail($sformatf("Mismatch at %0t: ir %h res_we/cr_we/illegal got %b expected %b",
                            $time, ir_v, {res_we_v, cr_we_v, illegal_v}, exp));
  endtask

  // ==========================================================
  // Issue rows [first, last) and check results as they leave
  // ==========================================================
  task automatic stream_rows(input int first, input int last, input bit random_ready);
    int   next_row;
    int   stall_in;
    int   stall_out;
    int   acc;
    bit   accept;
    bit   take;
    row_t exp;
    next_row  = first;
    stall_in  = 0;
    stall_out = 0;
    while (next_row < last || expect_q.size() > 0)
    begin
      @(negedge clk);
      cycle++;
      in_valid = next_row < last;
      if (next_row < last)
      begin
        ir  = rows[next_row].ir;
        ia  = rows[next_row].ia;
        id  = rows[next_row].id;
        cdb = rows[next_row].cdb;
      end
      out_ready = random_ready ? ($random(seed) & 1) : 1'b1;
      #1;
      accept = in_valid && in_ready;
      take   = out_valid && out_ready;
      if (take)
      begin
        if (expect_q.size() == 0)
          report_fail("A result left the unit with no issued instruction to match it");
        exp = expect_q.pop_front();
        acc = accept_q.pop_front();
        check_res(res, exp.res, exp.ir);
        check_cr(crres, exp.crres, exp.ir);
        check_flags(res_we, cr_we, illegal, exp.flags, exp.ir);
        // Accepted at the edge closing cycle acc, visible one cycle after that edge
        if (!random_ready && cycle != acc + 2)
          report_fail($sformatf("Mismatch at %0t: ir %h result came %0d cycles after issue",
                                $time, exp.ir, cycle - acc - 1));
        stall_out = 0;
      end
      else if (expect_q.size() > 0)
      begin
        stall_out++;
        if (stall_out > WAIT_LIMIT)
          report_fail("Timeout waiting for out_valid on an issued instruction");
      end
      if (accept)
      begin
        expect_q.push_back(rows[next_row]);
        accept_q.push_back(cycle);
        next_row++;
        stall_in = 0;
      end
      else if (in_valid)
      begin
        if (!random_ready)
          report_fail("in_ready dropped although out_ready was held high");
        stall_in++;
        if (stall_in > WAIT_LIMIT)
          report_fail("Timeout waiting for in_ready to accept an instruction");
      end
    end
  endtask

  initial
  begin
    logic [WID-1:0] ia_r;
    int             n_dir;
    seed      = 16;
    cycle     = 0;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    ir        = '0;
    ia        = '0;
    id        = '0;
    cdb       = '0;

    load_vectors();
    // TST sweep over every size, merge mode and both cdb extremes
    for (int s = 0; s < 4; s++)
      for (int m = 0; m < 5; m++)
        for (int c = 0; c < 2; c++)
        begin
          ia_r = {$random(seed), $random(seed)};
          rows.push_back(model_row(enc_ir(FN_TST, s, m), ia_r, ID0, c ? 8'hFF : 8'h00));
        end
    n_dir = rows.size();
    repeat (64)
    begin
      ia_r = {$random(seed), $random(seed)};
      if (($random(seed) & 3) == 0)
        ia_r[15:0] = '0;
      rows.push_back(model_row(enc_ir($unsigned($random(seed)) % 6, $random(seed) & 7,
                                      $unsigned($random(seed)) % 6),
                               ia_r, {$random(seed), $random(seed)}, $random(seed)));
    end

    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    #1;
    if (!in_ready || out_valid)
      report_fail("After reset in_ready is not high or out_valid is not low");

    stream_rows(0, n_dir, 1'b0);
    stream_rows(n_dir, rows.size(), 1'b1);

    // The last result was taken, so the result stage must now be empty
    @(negedge clk);
    #1;
    if (out_valid)
      report_fail("A result was repeated after the last issued instruction left the unit");

    $display("test passed");
    $finish;
  end

endmodule

// File: rtf64_r1.f
+incdir+sim
hw/rtf64_r1_pkg.sv
hw/r1_decode.sv
hw/r1_execute.sv
hw/r1_result.sv
hw/rtf64_r1_unit.sv
sim/r1_unit_tb.sv
